// ==== include/disp_macros.svh ====
// Widths, register map and raster timing for the display controller
// Timing is a tiny 8x4 visible frame, not a real VGA mode
`ifndef DISP_MACROS_SVH
`define DISP_MACROS_SVH

// Bus widths
`define ADDR_WIDTH     16        // MPU and VRAM address
`define DATA_WIDTH     16        // MPU and VRAM data
`define RGB_WIDTH      18        // RGB666 screen color

`define HCOUNT_WIDTH   10
`define VCOUNT_WIDTH   10

// Horizontal timing in clocks
`define H_ACTIVE       8
`define H_FRONT        1
`define H_SYNC         2
`define H_BACK         1
`define H_TOTAL        (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// Vertical timing in lines
`define V_ACTIVE       4
`define V_FRONT        1
`define V_SYNC         1
`define V_BACK         0
`define V_TOTAL        (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

`define REG_BASE       16'hFF00  // First control register
`define NUM_REGS       4
`define PIX_FIFO_DEPTH 4         // Also the fetch credit count

`endif

// ==== hdl/disp_pkg.sv ====
// Shared types for the display controller
// Field widths follow disp_macros.svh
`include "disp_macros.svh"

package disp_pkg;

  // One RGB565 framebuffer word
  typedef logic [15:0] pixel_t;

  // One MPU bus cycle
  typedef struct packed {
    logic                   en;
    logic                   rd;
    logic                   wr;
    logic [1:0]             be;     // Bit 0 is the low byte
    logic [`ADDR_WIDTH-1:0] addr;
    logic [`DATA_WIDTH-1:0] wdata;
  } mpu_req_t;

  // One VRAM access
  typedef struct packed {
    logic                   en;
    logic                   wr;     // Low means read
    logic [1:0]             be;
    logic [`ADDR_WIDTH-1:0] addr;
    logic [`DATA_WIDTH-1:0] wdata;
  } vram_req_t;

  // Register offsets from REG_BASE
  typedef enum logic [1:0] {
    REG_CTRL     = 2'd0,  // Bit 0 enables the display
    REG_FB_BASE  = 2'd1,
    REG_BG_COLOR = 2'd2,
    REG_STRIDE   = 2'd3
  } reg_idx_e;

  // Live register values for the fetcher and output stage
  typedef struct packed {
    logic                   enable;
    logic [`ADDR_WIDTH-1:0] fb_base;
    logic [`ADDR_WIDTH-1:0] stride;   // Words per framebuffer row
    pixel_t                 bg_color;
  } disp_cfg_t;

  // Raster position and flags
  typedef struct packed {
    logic [`HCOUNT_WIDTH-1:0] h_pos;
    logic [`VCOUNT_WIDTH-1:0] v_pos;
    logic                     hblank;
    logic                     vblank;
    logic                     frame_start;  // First clock of vsync
  } raster_t;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_RUN,
    FETCH_DONE
  } fetch_state_e;

endpackage

// ==== hdl/raster_timing.sv ====
// Raster counters with active-high sync, one clock per pixel
// hsync and vsync leave one clock late to line up with the registered pixels
`timescale 1ns/1ps
`include "disp_macros.svh"

module raster_timing (
  input  logic              clk,
  input  logic              rst_n,
  output disp_pkg::raster_t raster,
  output logic              hsync,
  output logic              vsync
);

  localparam int HW = `HCOUNT_WIDTH;
  localparam int VW = `VCOUNT_WIDTH;

  localparam logic [HW-1:0] H_LAST   = HW'(`H_TOTAL - 1);
  localparam logic [HW-1:0] H_ACT    = HW'(`H_ACTIVE);
  localparam logic [HW-1:0] HS_START = HW'(`H_ACTIVE + `H_FRONT);
  localparam logic [HW-1:0] HS_END   = HW'(`H_ACTIVE + `H_FRONT + `H_SYNC);
  localparam logic [VW-1:0] V_LAST   = VW'(`V_TOTAL - 1);
  localparam logic [VW-1:0] V_ACT    = VW'(`V_ACTIVE);
  localparam logic [VW-1:0] VS_START = VW'(`V_ACTIVE + `V_FRONT);
  localparam logic [VW-1:0] VS_END   = VW'(`V_ACTIVE + `V_FRONT + `V_SYNC);

  logic [HW-1:0] h_pos;
  logic [VW-1:0] v_pos;
  logic          line_end;   // Last clock of a line
  logic          hsync_win;  // Position inside the hsync window
  logic          vsync_win;

  assign line_end = (h_pos == H_LAST);

  // Position counters, v_pos steps at each line end
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_pos <= '0;
      v_pos <= '0;
    end else if (line_end) begin
      h_pos <= '0;
      v_pos <= (v_pos == V_LAST) ? '0 : v_pos + 1'b1;  // Frame wrap
    end else begin
      h_pos <= h_pos + 1'b1;
    end
  end

  assign hsync_win = (h_pos >= HS_START) && (h_pos < HS_END);
  assign vsync_win = (v_pos >= VS_START) && (v_pos < VS_END);

  // Delayed to match pixel_out
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hsync <= 1'b0;
      vsync <= 1'b0;
    end else begin
      hsync <= hsync_win;
      vsync <= vsync_win;
    end
  end

  assign raster.h_pos       = h_pos;
  assign raster.v_pos       = v_pos;
  assign raster.hblank      = (h_pos >= H_ACT);
  assign raster.vblank      = (v_pos >= V_ACT);
  assign raster.frame_start = (v_pos == VS_START) && (h_pos == '0);  // One clock per frame

  // Counter never runs past the line
  a_hpos_range : assert property (@(posedge clk) disable iff (!rst_n)
    h_pos <= H_LAST);

endmodule

// ==== hdl/host_decode.sv ====
// MPU decode and control registers, the MPU is never stalled
// Reads return one clock after the request, for registers and VRAM alike
`timescale 1ns/1ps
`include "disp_macros.svh"

module host_decode (
  input  logic                   clk,
  input  logic                   rst_n,
  input  disp_pkg::mpu_req_t     mpu_req,
  input  logic [`DATA_WIDTH-1:0] vram_rdata,
  output logic [`DATA_WIDTH-1:0] mpu_rdata,
  output logic                   mpu_rvalid,
  output disp_pkg::vram_req_t    host_vram,
  output disp_pkg::disp_cfg_t    cfg
);
  import disp_pkg::*;

  localparam int AW = `ADDR_WIDTH;
  localparam int DW = `DATA_WIDTH;
  localparam int NB = DW / 8;  // Bytes per word

  localparam logic [AW-1:0] REG_LO = `REG_BASE;
  localparam logic [AW-1:0] REG_HI = AW'(`REG_BASE + `NUM_REGS - 1);

  logic [DW-1:0] regs [`NUM_REGS];
  logic          reg_sel;      // Cycle targets a register
  reg_idx_e      reg_idx;
  logic          rd_reg_q;     // Last read was a register read
  logic [DW-1:0] reg_rdata_q;

  assign reg_sel = mpu_req.en && (mpu_req.addr >= REG_LO) && (mpu_req.addr <= REG_HI);
  assign reg_idx = reg_idx_e'(mpu_req.addr[1:0]);

  // Byte-merged register writes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_sel && mpu_req.wr) begin
      for (int b = 0; b < NB; b++) begin
        if (mpu_req.be[b]) begin
          regs[reg_idx][8*b +: 8] <= mpu_req.wdata[8*b +: 8];  // Untouched bytes kept
        end
      end
    end
  end

  // Read return tracking
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mpu_rvalid <= 1'b0;
      rd_reg_q   <= 1'b0;
    end else begin
      mpu_rvalid <= mpu_req.en && mpu_req.rd;
      rd_reg_q   <= reg_sel && mpu_req.rd;
    end
  end

  always_ff @(posedge clk) begin
    if (reg_sel && mpu_req.rd) begin
      reg_rdata_q <= regs[reg_idx];
    end
  end

  // VRAM data arrives one clock after the request
  assign mpu_rdata = rd_reg_q ? reg_rdata_q : vram_rdata;

  // Everything outside the register window goes to VRAM
  always_comb begin
    host_vram.en    = mpu_req.en && !reg_sel && (mpu_req.rd || mpu_req.wr);
    host_vram.wr    = mpu_req.wr;
    host_vram.be    = mpu_req.be;
    host_vram.addr  = mpu_req.addr;
    host_vram.wdata = mpu_req.wdata;
  end

  assign cfg.enable   = regs[REG_CTRL][0];
  assign cfg.fb_base  = regs[REG_FB_BASE];
  assign cfg.stride   = regs[REG_STRIDE];
  assign cfg.bg_color = regs[REG_BG_COLOR];

  // MPU protocol check
  a_rd_wr_excl : assert property (@(posedge clk) disable iff (!rst_n)
    mpu_req.en |-> !(mpu_req.rd && mpu_req.wr));

endmodule

// ==== hdl/vram_arbiter.sv ====
// Fixed priority VRAM mux, host first, fetcher otherwise
// VRAM read data is assumed valid one clock after the request
`timescale 1ns/1ps
`include "disp_macros.svh"

module vram_arbiter (
  input  logic                   clk,
  input  logic                   rst_n,
  input  disp_pkg::vram_req_t    host_vram,
  input  disp_pkg::vram_req_t    gpu_vram,
  output disp_pkg::vram_req_t    vram_req,
  output logic                   gpu_grant,
  output logic                   gpu_rvalid,
  input  logic [`DATA_WIDTH-1:0] vram_rdata,
  output logic [`DATA_WIDTH-1:0] gpu_rdata
);

  logic host_grant;
  logic gpu_own_q;  // Fetcher owned the previous read

  assign host_grant = host_vram.en;               // Host always wins
  assign gpu_grant  = gpu_vram.en && !host_grant; // Fetcher waits otherwise

  always_comb begin
    if (host_grant) begin
      vram_req = host_vram;
    end else if (gpu_grant) begin
      vram_req = gpu_vram;
    end else begin
      vram_req = '0;  // Idle bus
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gpu_own_q <= 1'b0;
    end else begin
      gpu_own_q <= gpu_grant && !gpu_vram.wr;
    end
  end

  // Data goes back to the fetcher only after its own read
  assign gpu_rvalid = gpu_own_q;
  assign gpu_rdata  = vram_rdata;

  // Only the host ever writes VRAM
  a_host_only_writes : assert property (@(posedge clk) disable iff (!rst_n)
    vram_req.en && vram_req.wr |-> host_grant);

endmodule

// ==== hdl/pixel_fetch.sv ====
// Raster-order framebuffer reads, one credit per read
// Base, stride and enable are taken at frame start only
`timescale 1ns/1ps
`include "disp_macros.svh"

module pixel_fetch #(
  parameter int CREDITS = `PIX_FIFO_DEPTH
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  disp_pkg::raster_t      raster,
  input  disp_pkg::disp_cfg_t    cfg,
  output disp_pkg::vram_req_t    gpu_vram,
  input  logic                   gpu_grant,
  input  logic                   gpu_rvalid,
  input  logic [`DATA_WIDTH-1:0] gpu_rdata,
  input  logic                   credit_return,
  output disp_pkg::pixel_t       pix,
  output logic                   pix_valid
);
  import disp_pkg::*;

  localparam int AW = `ADDR_WIDTH;
  localparam int HW = `HCOUNT_WIDTH;
  localparam int VW = `VCOUNT_WIDTH;
  localparam int CW = $clog2(CREDITS + 1);

  localparam logic [HW-1:0] COL_LAST = HW'(`H_ACTIVE - 1);
  localparam logic [VW-1:0] ROW_LAST = VW'(`V_ACTIVE - 1);

  fetch_state_e  state;
  logic [CW-1:0] credits;
  logic [HW-1:0] col;
  logic [VW-1:0] row;
  logic [AW-1:0] row_base;  // fb_base + row * stride
  logic [AW-1:0] stride_q;
  logic          issue;     // Read accepted this clock
  logic          drop_q;    // Clock after frame start

  // Read request, never without a credit
  assign gpu_vram.en    = (state == FETCH_RUN) && (credits != '0);
  assign gpu_vram.wr    = 1'b0;
  assign gpu_vram.be    = '1;
  assign gpu_vram.addr  = row_base + AW'(col);
  assign gpu_vram.wdata = '0;

  assign issue = gpu_vram.en && gpu_grant;

  // Walk the visible frame
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= FETCH_IDLE;
      col      <= '0;
      row      <= '0;
      row_base <= '0;
      stride_q <= '0;
    end else if (raster.frame_start) begin
      state    <= cfg.enable ? FETCH_RUN : FETCH_IDLE;  // Disabled frame stays idle
      col      <= '0;
      row      <= '0;
      row_base <= cfg.fb_base;
      stride_q <= cfg.stride;
    end else if (issue) begin
      if (col == COL_LAST) begin
        col      <= '0;
        row      <= row + 1'b1;
        row_base <= row_base + stride_q;  // Next framebuffer row
        if (row == ROW_LAST) begin
          state <= FETCH_DONE;  // Wait for the next frame
        end
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  // Credits refill at every frame start along with the FIFO flush
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits <= CW'(CREDITS);
      drop_q  <= 1'b0;
    end else begin
      drop_q <= raster.frame_start;
      if (raster.frame_start) begin
        credits <= CW'(CREDITS);
      end else begin
        credits <= credits - CW'(issue) + CW'(credit_return);
      end
    end
  end

  // Stale word from the old frame is dropped
  assign pix       = gpu_rdata;
  assign pix_valid = gpu_rvalid && !drop_q;

  // pixel_out never returns more than was spent
  a_credit_max : assert property (@(posedge clk) disable iff (!rst_n)
    credits <= CW'(CREDITS));

endmodule

// ==== hdl/pixel_out.sv ====
// Pixel FIFO, RGB565 to RGB666 and screen drive, outputs one clock late
// An empty FIFO during an active pixel shows bg_color
`timescale 1ns/1ps
`include "disp_macros.svh"

module pixel_out #(
  parameter int DEPTH = `PIX_FIFO_DEPTH
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  disp_pkg::raster_t     raster,
  input  disp_pkg::disp_cfg_t   cfg,
  input  disp_pkg::pixel_t      pix,
  input  logic                  pix_valid,
  output logic                  credit_return,
  output logic                  vga_de,
  output logic [`RGB_WIDTH-1:0] vga_rgb
);
  import disp_pkg::*;

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  pixel_t        mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          active;  // Visible pixel this clock
  logic          empty;
  logic          full;
  logic          pop;

  // 5-bit fields get their MSB copied down, green passes
  function automatic logic [`RGB_WIDTH-1:0] rgb565_to_666(input pixel_t p);
    return {p[15:11], p[15], p[10:5], p[4:0], p[4]};
  endfunction

  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign active        = !raster.hblank && !raster.vblank;
  assign empty         = (count == '0);
  assign full          = (count == CW'(DEPTH));
  assign pop           = active && !empty;  // Pops even when disabled
  assign credit_return = pop;

  // FIFO control, flushed at frame start
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (raster.frame_start) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (pix_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + CW'(pix_valid) - CW'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (pix_valid) begin
      mem[wr_ptr] <= pix;
    end
  end

  // Registered screen outputs
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vga_de  <= 1'b0;
      vga_rgb <= '0;
    end else begin
      vga_de <= active;
      if (!active) begin
        vga_rgb <= '0;                             // Blanking
      end else if (cfg.enable && !empty) begin
        vga_rgb <= rgb565_to_666(mem[rd_ptr]);
      end else begin
        vga_rgb <= rgb565_to_666(cfg.bg_color);    // Disabled or underflow
      end
    end
  end

  // Fetcher credits keep the FIFO from overflowing
  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
    pix_valid && !raster.frame_start |-> !full);

endmodule

// ==== hdl/disp_top.sv ====
// Display controller top, MPU bus in, VRAM bus and screen out
// Request and read data use separate ports, no tristate buses
`timescale 1ns/1ps
`include "disp_macros.svh"

module disp_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  disp_pkg::mpu_req_t     mpu_req,
  output logic [`DATA_WIDTH-1:0] mpu_rdata,
  output logic                   mpu_rvalid,
  output disp_pkg::vram_req_t    vram_req,
  input  logic [`DATA_WIDTH-1:0] vram_rdata,
  output logic                   hsync,
  output logic                   vsync,
  output logic                   vga_de,
  output logic [`RGB_WIDTH-1:0]  vga_rgb
);
  import disp_pkg::*;

  raster_t                raster;
  disp_cfg_t              cfg;
  vram_req_t              host_vram;      // Decoded MPU access to VRAM
  vram_req_t              gpu_vram;       // Fetcher reads
  logic                   gpu_grant;
  logic                   gpu_rvalid;
  logic [`DATA_WIDTH-1:0] gpu_rdata;
  pixel_t                 pix;
  logic                   pix_valid;
  logic                   credit_return;  // One per popped pixel

  raster_timing u_raster (
    .clk    (clk),
    .rst_n  (rst_n),
    .raster (raster),
    .hsync  (hsync),
    .vsync  (vsync)
  );

  host_decode u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .mpu_req    (mpu_req),
    .vram_rdata (vram_rdata),
    .mpu_rdata  (mpu_rdata),
    .mpu_rvalid (mpu_rvalid),
    .host_vram  (host_vram),
    .cfg        (cfg)
  );

  vram_arbiter u_arb (
    .clk        (clk),
    .rst_n      (rst_n),
    .host_vram  (host_vram),
    .gpu_vram   (gpu_vram),
    .vram_req   (vram_req),
    .gpu_grant  (gpu_grant),
    .gpu_rvalid (gpu_rvalid),
    .vram_rdata (vram_rdata),
    .gpu_rdata  (gpu_rdata)
  );

  pixel_fetch #(.CREDITS(`PIX_FIFO_DEPTH)) u_fetch (
    .clk           (clk),
    .rst_n         (rst_n),
    .raster        (raster),
    .cfg           (cfg),
    .gpu_vram      (gpu_vram),
    .gpu_grant     (gpu_grant),
    .gpu_rvalid    (gpu_rvalid),
    .gpu_rdata     (gpu_rdata),
    .credit_return (credit_return),
    .pix           (pix),
    .pix_valid     (pix_valid)
  );

  pixel_out #(.DEPTH(`PIX_FIFO_DEPTH)) u_out (
    .clk           (clk),
    .rst_n         (rst_n),
    .raster        (raster),
    .cfg           (cfg),
    .pix           (pix),
    .pix_valid     (pix_valid),
    .credit_return (credit_return),
    .vga_de        (vga_de),
    .vga_rgb       (vga_rgb)
  );

endmodule

// ==== testbench/vram_model.sv ====
// Synchronous VRAM with one clock read latency and byte-enable writes
// Full 64K-word space, preloaded with a pattern built from the whole address
`timescale 1ns/1ps
`include "disp_macros.svh"

module vram_model (
  input  logic                   clk,
  input  disp_pkg::vram_req_t    vram_req,
  output logic [`DATA_WIDTH-1:0] vram_rdata
);

  localparam int DW    = `DATA_WIDTH;
  localparam int NB    = DW / 8;
  localparam int WORDS = 1 << `ADDR_WIDTH;

  logic [DW-1:0] mem [WORDS];

  // Odd multiplier keeps every address distinct
  initial begin
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = DW'(i * 40503) ^ 16'h5A5A;
    end
    vram_rdata <= '0;
  end

  always @(posedge clk) begin
    if (vram_req.en) begin
      if (vram_req.wr) begin
        for (int b = 0; b < NB; b++) begin
          if (vram_req.be[b]) begin
            mem[vram_req.addr][8*b +: 8] = vram_req.wdata[8*b +: 8];  // Byte merge
          end
        end
      end else begin
        vram_rdata <= mem[vram_req.addr];  // Valid next clock
      end
    end
  end

endmodule

// ==== testbench/tb_disp.sv ====
// Directed testbench for disp_top, VRAM answered by vram_model
// Frame checks assume the tiny raster from disp_macros.svh
`timescale 1ns/1ps
`include "disp_macros.svh"

module tb_disp;
  import disp_pkg::*;

  localparam int AW      = `ADDR_WIDTH;
  localparam int DW      = `DATA_WIDTH;
  localparam int RW      = `RGB_WIDTH;
  localparam int NPIX    = `H_ACTIVE * `V_ACTIVE;
  localparam int STRIDE  = 10;
  localparam int TIMEOUT = 4 * `H_TOTAL * `V_TOTAL;  // Cycles allowed per wait loop
  localparam int NHSYNC  = `H_SYNC * `V_TOTAL;        // hsync clocks per frame
  localparam logic [AW-1:0] BASE_A = 16'h1000;
  localparam logic [AW-1:0] BASE_B = 16'h2340;

  logic          clk;
  logic          rst_n;
  mpu_req_t      mpu_req;
  logic [DW-1:0] mpu_rdata;
  logic          mpu_rvalid;
  vram_req_t     vram_req;
  logic [DW-1:0] vram_rdata;
  logic          hsync;
  logic          vsync;
  logic          vga_de;
  logic [RW-1:0] vga_rgb;
  logic [31:0]   lcg_state;
  logic [DW-1:0] fb_exp [2][NPIX];  // Expected words per region
  logic [RW-1:0] frame_rgb [NPIX];  // Captured visible pixels

  disp_top dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .mpu_req    (mpu_req),
    .mpu_rdata  (mpu_rdata),
    .mpu_rvalid (mpu_rvalid),
    .vram_req   (vram_req),
    .vram_rdata (vram_rdata),
    .hsync      (hsync),
    .vsync      (vsync),
    .vga_de     (vga_de),
    .vga_rgb    (vga_rgb)
  );

  vram_model u_vram (
    .clk        (clk),
    .vram_req   (vram_req),
    .vram_rdata (vram_rdata)
  );

  always #2 clk = ~clk;  // 4 ns period

  function automatic logic [DW-1:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];  // Upper bits, better spread
  endfunction

  // RGB565 to RGB666, red and blue widened by their own MSB
  function automatic logic [RW-1:0] rgb_expand(input pixel_t p);
    logic [5:0] r6;
    logic [5:0] g6;
    logic [5:0] b6;
    r6 = {p[15:11], p[15]};
    g6 = p[10:5];
    b6 = {p[4:0], p[4]};
    return {r6, g6, b6};
  endfunction

  function automatic logic [AW-1:0] reg_addr(input reg_idx_e r);
    return `REG_BASE + AW'(r);
  endfunction

  task automatic check_word(input string name, input logic [DW-1:0] exp,
                            input logic [DW-1:0] act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  task automatic check_rgb(input string name, input logic [RW-1:0] exp,
                           input logic [RW-1:0] act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("Fail %s expected %0d actual %0d", name, exp, act);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string name, input string what);
    $display("Timeout in %s, no %s within %0d cycles", name, what, TIMEOUT);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic apply_reset();
    rst_n   = 1'b0;
    mpu_req = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  endtask

  // One write cycle, bus idle again on the next falling edge
  task automatic mpu_write(input logic [AW-1:0] addr, input logic [1:0] be,
                           input logic [DW-1:0] data);
    @(negedge clk);
    mpu_req       = '0;
    mpu_req.en    = 1'b1;
    mpu_req.wr    = 1'b1;
    mpu_req.be    = be;
    mpu_req.addr  = addr;
    mpu_req.wdata = data;
    @(negedge clk);
    mpu_req = '0;
  endtask

  // Read data is due exactly one clock after the request
  task automatic read_check(input string name, input logic [AW-1:0] addr,
                            input logic [DW-1:0] exp);
    @(negedge clk);
    mpu_req      = '0;
    mpu_req.en   = 1'b1;
    mpu_req.rd   = 1'b1;
    mpu_req.be   = 2'b11;
    mpu_req.addr = addr;
    @(negedge clk);
    mpu_req = '0;
    check_count({name, " rvalid"}, 1, int'(mpu_rvalid));
    check_word(name, exp, mpu_rdata);
  endtask

  task automatic wait_vsync_rise(input string name);
    logic prev;
    logic seen;
    int   n;
    prev = vsync;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < TIMEOUT) begin
      @(negedge clk);
      seen = vsync && !prev;
      prev = vsync;
      n++;
    end
    if (!seen) report_timeout(name, "vsync edge");
  endtask

  // Collects vga_de pixels and hsync clocks up to the next vsync rise
  task automatic capture_frame(input string name, output int count,
                               output int hs_count);
    logic prev;
    logic done;
    int   n;
    prev     = vsync;
    done     = 1'b0;
    n        = 0;
    count    = 0;
    hs_count = 0;
    while (!done && n < TIMEOUT) begin
      @(negedge clk);
      if (hsync) hs_count++;  // Two clocks in every line
      if (vsync && !prev) begin
        done = 1'b1;
      end else if (vga_de) begin
        if (count < NPIX) frame_rgb[count] = vga_rgb;
        count++;
      end
      prev = vsync;
      n++;
    end
    if (!done) report_timeout(name, "frame end");
  endtask

  task automatic check_frame(input string name, input int region);
    int n;
    int hs;
    capture_frame(name, n, hs);
    check_count({name, " pixel count"}, NPIX, n);
    check_count({name, " hsync clocks"}, NHSYNC, hs);
    for (int k = 0; k < NPIX; k++) begin
      check_rgb($sformatf("%s row %0d col %0d", name, k / `H_ACTIVE, k % `H_ACTIVE),
                rgb_expand(fb_exp[region][k]), frame_rgb[k]);
    end
  endtask

  task automatic fill_region(input int region, input logic [AW-1:0] base);
    logic [DW-1:0] w;
    for (int r = 0; r < `V_ACTIVE; r++) begin
      for (int c = 0; c < `H_ACTIVE; c++) begin
        w = next_rand();
        fb_exp[region][r * `H_ACTIVE + c] = w;
        mpu_write(base + AW'(r * STRIDE + c), 2'b11, w);
      end
    end
  endtask

  task automatic test_reset_state();
    check_count("reset vram_req.en", 0, int'(vram_req.en));
    check_count("reset mpu_rvalid", 0, int'(mpu_rvalid));
    check_count("reset vga_de", 0, int'(vga_de));
    check_rgb("reset vga_rgb", '0, vga_rgb);
  endtask

  // Four byte-enable patterns per register, expected value merged here
  task automatic test_registers();
    logic [DW-1:0] exp_reg [`NUM_REGS];
    logic [DW-1:0] wdata;
    logic [1:0]    be;
    for (int i = 0; i < `NUM_REGS; i++) exp_reg[i] = '0;
    for (int k = 0; k < 4; k++) begin
      be = (k == 0) ? 2'b11 : (k == 1) ? 2'b01 : (k == 2) ? 2'b10 : 2'b00;
      for (int i = 0; i < `NUM_REGS; i++) begin
        wdata = next_rand();
        mpu_write(reg_addr(reg_idx_e'(i)), be, wdata);
        if (be[0]) exp_reg[i][7:0] = wdata[7:0];
        if (be[1]) exp_reg[i][15:8] = wdata[15:8];
        read_check($sformatf("register %0d be %b", i, be), reg_addr(reg_idx_e'(i)),
                   exp_reg[i]);
      end
    end
    for (int i = 0; i < `NUM_REGS; i++) begin
      mpu_write(reg_addr(reg_idx_e'(i)), 2'b11, '0);  // Display off again
    end
  endtask

  task automatic test_vram_access();
    logic [DW-1:0] exp_mem [16];
    logic [DW-1:0] w;
    for (int i = 0; i < 16; i++) begin
      exp_mem[i] = next_rand();
      mpu_write(AW'(16'h0400 + i * 37), 2'b11, exp_mem[i]);
    end
    w = next_rand();
    mpu_write(16'h0400, 2'b01, w);  // Low byte only
    exp_mem[0][7:0] = w[7:0];
    for (int i = 0; i < 16; i++) begin
      read_check($sformatf("vram word %0d", i), AW'(16'h0400 + i * 37), exp_mem[i]);
    end
  endtask

  task automatic test_display_disabled();
    logic [DW-1:0] bg;
    int            n;
    int            hs;
    bg = next_rand();
    mpu_write(reg_addr(REG_BG_COLOR), 2'b11, bg);
    mpu_write(reg_addr(REG_CTRL), 2'b11, '0);
    wait_vsync_rise("disabled sync");
    capture_frame("disabled frame", n, hs);
    check_count("disabled pixel count", NPIX, n);
    check_count("disabled hsync clocks", NHSYNC, hs);
    for (int k = 0; k < NPIX; k++) begin
      check_rgb($sformatf("disabled pixel %0d", k), rgb_expand(bg), frame_rgb[k]);
    end
  endtask

  task automatic test_framebuffer();
    fill_region(0, BASE_A);
    fill_region(1, BASE_B);
    mpu_write(reg_addr(REG_STRIDE), 2'b11, DW'(STRIDE));
    mpu_write(reg_addr(REG_FB_BASE), 2'b11, BASE_A);
    mpu_write(reg_addr(REG_CTRL), 2'b11, 16'h0001);
    wait_vsync_rise("framebuffer sync");  // Settings latched at this frame start
    check_frame("frame base A", 0);
    mpu_write(reg_addr(REG_FB_BASE), 2'b11, BASE_B);  // Lands inside vsync, frame already latched
    check_frame("frame base A held", 0);
    check_frame("frame base B", 1);
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    mpu_req   = '0;
    lcg_state = 32'd58;
    apply_reset();
    test_reset_state();
    test_registers();
    test_vram_access();
    test_display_disabled();
    test_framebuffer();
    $display("Verification passed");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+include
hdl/disp_pkg.sv
hdl/raster_timing.sv
hdl/host_decode.sv
hdl/vram_arbiter.sv
hdl/pixel_fetch.sv
hdl/pixel_out.sv
hdl/disp_top.sv
testbench/vram_model.sv
testbench/tb_disp.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_disp
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The log decides pass or fail
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
